// File: build.f
+incdir+include
logic/riscv_types_pkg.sv
logic/hazard_pkg.sv
logic/reg_dep_check.sv
logic/store_load_check.sv
logic/stall_arbiter.sv
logic/hazard_unit.sv
sim/tb_clock_gen.sv
sim/hazard_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the hazard unit testbench with Verilator.

if ! cd "$(dirname "$0")"; then
    echo "cannot enter project root"
    exit 1
fi

LOG=sim.log

verilator --binary --timing -f build.f --top-module hazard_unit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vhazard_unit_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

exit 0

// File: sim/hazard_unit_tb.sv
`include "hazard_macros.svh"

module hazard_unit_tb;

    localparam int RESET_CYCLES    = 2;
    localparam int DIRECTED_CYCLES = 64;     // upper bound on the directed part
    localparam int RANDOM_CYCLES   = 4000;
    localparam int TIMEOUT = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 8 + 400;
    localparam riscv_types_pkg::xlen_t RUN_PC = 64'h1000;

    logic clk;
    logic rst_n;
    riscv_types_pkg::xlen_t     id_pc;
    riscv_types_pkg::reg_addr_t rs1_addr;
    riscv_types_pkg::reg_addr_t rs2_addr;
    riscv_types_pkg::mem_op_t   id_mem_op;
    riscv_types_pkg::xlen_t     id_base;
    riscv_types_pkg::imm_t      id_imm;
    riscv_types_pkg::reg_addr_t ex_rd_addr;
    riscv_types_pkg::mem_op_t   ex_mem_op;
    riscv_types_pkg::xlen_t     ex_store_addr;
    riscv_types_pkg::reg_addr_t wb_rd_addr;
    logic stall_id;
    logic stall_mem;
    logic stall_wb;
    logic stall_store_load;

    logic [31:0] lfsr_state = 32'hf3f35a85;
    riscv_types_pkg::xlen_t cur_pc;
    logic       mem_is_store;
    logic       prev_mem;      // model of the arbiter hold state
    logic [3:0] want;          // {id, mem, wb, store_load}
    int         mem_cycles;
    int         sl_cycles;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hazard_unit i_hazard_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .id_pc            (id_pc),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .id_mem_op        (id_mem_op),
        .id_base          (id_base),
        .id_imm           (id_imm),
        .ex_rd_addr       (ex_rd_addr),
        .ex_mem_op        (ex_mem_op),
        .ex_store_addr    (ex_store_addr),
        .wb_rd_addr       (wb_rd_addr),
        .mem_is_store     (mem_is_store),
        .stall_id         (stall_id),
        .stall_mem        (stall_mem),
        .stall_wb         (stall_wb),
        .stall_store_load (stall_store_load)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic riscv_types_pkg::mem_op_t rand_op();
        logic [63:0] v;
        v = rand_bits(4);
        if (v > 64'd11) v = '0;   // codes above SD mean no access
        return riscv_types_pkg::mem_op_t'(v[3:0]);
    endfunction

    function automatic int op_size(input riscv_types_pkg::mem_op_t op);
        case (op)
            riscv_types_pkg::MEM_LB, riscv_types_pkg::MEM_LBU, riscv_types_pkg::MEM_SB: return 1;
            riscv_types_pkg::MEM_LH, riscv_types_pkg::MEM_LHU, riscv_types_pkg::MEM_SH: return 2;
            riscv_types_pkg::MEM_LW, riscv_types_pkg::MEM_LWU, riscv_types_pkg::MEM_SW: return 4;
            riscv_types_pkg::MEM_LD, riscv_types_pkg::MEM_SD: return 8;
            default: return 0;
        endcase
    endfunction

    // aligned address in one of two doublewords
    function automatic riscv_types_pkg::xlen_t aligned_addr(input int size);
        logic [63:0] sz;
        logic [63:0] dw;
        logic [63:0] off;
        sz  = 64'(size);
        dw  = rand_bits(1);
        off = rand_bits(3);
        return 64'h2000 + (dw << 3) + (off & ~(sz - 64'd1));
    endfunction

    function automatic riscv_types_pkg::xlen_t sext_imm(input riscv_types_pkg::imm_t imm);
        return {{(`HZ_XLEN-`HZ_IMM_WIDTH){imm[`HZ_IMM_WIDTH-1]}}, imm};
    endfunction

    // expected stalls from the priority tables
    function automatic logic [3:0] expected_stalls(
        input riscv_types_pkg::xlen_t     pc,
        input riscv_types_pkg::reg_addr_t rs1,
        input riscv_types_pkg::reg_addr_t rs2,
        input riscv_types_pkg::mem_op_t   id_op,
        input riscv_types_pkg::xlen_t     base,
        input riscv_types_pkg::imm_t      imm,
        input riscv_types_pkg::reg_addr_t ex_rd,
        input riscv_types_pkg::mem_op_t   ex_op,
        input riscv_types_pkg::xlen_t     st_addr,
        input riscv_types_pkg::reg_addr_t wb_rd,
        input logic                       mis,
        input logic                       hold
    );
        riscv_types_pkg::xlen_t la;
        logic ex_st;
        logic ex_m;
        logic wb_m;
        logic dual;
        logic long_ld;
        logic ovl;
        int   lo;
        int   so;
        int   lane;
        ex_st = (ex_op >= riscv_types_pkg::MEM_SB) && (ex_op <= riscv_types_pkg::MEM_SD);
        ex_m  = (ex_rd != 0) && !ex_st && (rs1 == ex_rd || rs2 == ex_rd);
        wb_m  = (wb_rd != 0) && !mis && (rs1 == wb_rd || rs2 == wb_rd);
        dual  = (ex_rd != 0) && (wb_rd != 0)
                && ((rs1 == ex_rd && rs2 == wb_rd) || (rs2 == ex_rd && rs1 == wb_rd));
        long_ld = (ex_op == riscv_types_pkg::MEM_LB) || (ex_op == riscv_types_pkg::MEM_LH)
                  || (ex_op == riscv_types_pkg::MEM_LW);
        la  = base + sext_imm(imm);
        lo  = int'(la[2:0]);
        so  = int'(st_addr[2:0]);
        ovl = 1'b0;
        if ((id_op >= riscv_types_pkg::MEM_LB) && (id_op <= riscv_types_pkg::MEM_LWU) && ex_st
            && (la[63:3] == st_addr[63:3])) begin
            for (lane = 0; lane < 8; lane++) begin
                if (lane >= lo && lane < lo + op_size(id_op)
                    && lane >= so && lane < so + op_size(ex_op)) ovl = 1'b1;
            end
        end
        if (pc == `HZ_PC_NULL || pc == `HZ_PC_BOOT || hold) return 4'b0000;
        if (long_ld) begin
            if (dual) return 4'b1110;
            if (ex_m) return 4'b1100;
            if (wb_m) return 4'b1010;
            return 4'b0000;
        end
        if (dual) return 4'b1010;
        if (ex_m) return 4'b1000;
        if (wb_m) return 4'b1010;
        if (ovl)  return 4'b1001;
        return 4'b0000;
    endfunction

    task automatic check_value(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic clear_inputs();
        id_pc         = cur_pc;
        rs1_addr      = '0;
        rs2_addr      = '0;
        id_mem_op     = riscv_types_pkg::MEM_NONE;
        id_base       = '0;
        id_imm        = '0;
        ex_rd_addr    = '0;
        ex_mem_op     = riscv_types_pkg::MEM_NONE;
        ex_store_addr = '0;
        wb_rd_addr    = '0;
        mem_is_store  = 1'b0;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic drive_regs(
        input riscv_types_pkg::reg_addr_t rs1,
        input riscv_types_pkg::reg_addr_t rs2,
        input riscv_types_pkg::reg_addr_t ex_rd,
        input riscv_types_pkg::mem_op_t   ex_op,
        input riscv_types_pkg::reg_addr_t wb_rd,
        input logic                       mis
    );
        @(negedge clk);
        clear_inputs();
        rs1_addr     = rs1;
        rs2_addr     = rs2;
        ex_rd_addr   = ex_rd;
        ex_mem_op    = ex_op;
        wb_rd_addr   = wb_rd;
        mem_is_store = mis;
    endtask

    task automatic drive_mem(
        input riscv_types_pkg::mem_op_t id_op,
        input riscv_types_pkg::xlen_t   la,
        input riscv_types_pkg::imm_t    imm,
        input riscv_types_pkg::mem_op_t ex_op,
        input riscv_types_pkg::xlen_t   st
    );
        @(negedge clk);
        clear_inputs();
        id_mem_op     = id_op;
        id_imm        = imm;
        id_base       = la - sext_imm(imm);   // base chosen so base + imm lands on la
        ex_mem_op     = ex_op;
        ex_store_addr = st;
    endtask

    task automatic random_cycle();
        logic [63:0] v;
        @(negedge clk);
        v = rand_bits(3);
        if (v == 64'd0) begin
            id_pc = `HZ_PC_NULL;
        end else if (v == 64'd1) begin
            id_pc = `HZ_PC_BOOT;
        end else begin
            v = rand_bits(10);
            id_pc = RUN_PC + (v << 2);
        end
        rs1_addr   = riscv_types_pkg::reg_addr_t'(rand_bits(2));   // x0..x3 keeps hits frequent
        rs2_addr   = riscv_types_pkg::reg_addr_t'(rand_bits(2));
        ex_rd_addr = riscv_types_pkg::reg_addr_t'(rand_bits(2));
        wb_rd_addr = riscv_types_pkg::reg_addr_t'(rand_bits(2));
        v = rand_bits(1);
        mem_is_store  = v[0];
        id_mem_op     = rand_op();
        ex_mem_op     = rand_op();
        ex_store_addr = aligned_addr(op_size(ex_mem_op));
        v = rand_bits(5);
        id_imm  = riscv_types_pkg::imm_t'({{27{v[4]}}, v[4:0]});
        id_base = aligned_addr(op_size(id_mem_op)) - sext_imm(id_imm);
    endtask

    // compare before the arbiter state updates on this edge
    always @(posedge clk) begin
        if (!rst_n) begin
            prev_mem = 1'b0;
            check_value("stall_id", stall_id, 1'b0);
            check_value("stall_mem", stall_mem, 1'b0);
            check_value("stall_wb", stall_wb, 1'b0);
            check_value("stall_store_load", stall_store_load, 1'b0);
        end else begin
            want = expected_stalls(id_pc, rs1_addr, rs2_addr, id_mem_op, id_base, id_imm,
                                   ex_rd_addr, ex_mem_op, ex_store_addr, wb_rd_addr,
                                   mem_is_store, prev_mem);
            check_value("stall_id", stall_id, want[3]);
            check_value("stall_mem", stall_mem, want[2]);
            check_value("stall_wb", stall_wb, want[1]);
            check_value("stall_store_load", stall_store_load, want[0]);
            if (want[2]) mem_cycles++;
            if (want[0]) sl_cycles++;
            prev_mem = want[2];
        end
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        riscv_types_pkg::mem_op_t op;
        int k;
        int lane;
        int n;
        mem_cycles = 0;
        sl_cycles  = 0;
        cur_pc     = `HZ_PC_NULL;
        clear_inputs();
        @(posedge rst_n);

        // hazards while decode holds no real instruction
        drive_regs(5'd1, 5'd2, 5'd1, riscv_types_pkg::MEM_LW, 5'd2, 1'b0);
        cur_pc = `HZ_PC_BOOT;
        drive_regs(5'd1, 5'd2, 5'd1, riscv_types_pkg::MEM_LW, 5'd2, 1'b0);
        cur_pc = RUN_PC;

        for (k = 0; k < 2; k++) begin
            op = (k == 1) ? riscv_types_pkg::MEM_LW : riscv_types_pkg::MEM_NONE;
            drive_regs(5'd1, 5'd2, 5'd1, op, 5'd2, 1'b0);   // dual
            idle_cycle();
            idle_cycle();
            drive_regs(5'd3, 5'd4, 5'd3, op, 5'd5, 1'b0);   // ex only
            idle_cycle();
            idle_cycle();
            drive_regs(5'd3, 5'd6, 5'd7, op, 5'd6, 1'b0);   // wb only
            idle_cycle();
            idle_cycle();
            drive_regs(5'd0, 5'd4, 5'd0, op, 5'd0, 1'b0);   // x0 never stalls
            idle_cycle();
        end
        drive_regs(5'd3, 5'd4, 5'd3, riscv_types_pkg::MEM_SD, 5'd0, 1'b0);
        drive_regs(5'd3, 5'd4, 5'd0, riscv_types_pkg::MEM_NONE, 5'd3, 1'b1);

        // mem stall, masked cycle, then stall again
        repeat (4) drive_regs(5'd3, 5'd4, 5'd3, riscv_types_pkg::MEM_LH, 5'd0, 1'b0);
        idle_cycle();

        // byte load sweeping the lanes around a halfword store at lanes 2 and 3
        for (lane = 0; lane < 8; lane++) begin
            drive_mem(riscv_types_pkg::MEM_LB, 64'h3000 + 64'(lane),
                      (lane % 2 == 1) ? riscv_types_pkg::imm_t'(-16) : 32'd24,
                      riscv_types_pkg::MEM_SH, 64'h3002);
        end
        drive_mem(riscv_types_pkg::MEM_LW, 64'h3004, 32'd8, riscv_types_pkg::MEM_SW, 64'h3000);
        drive_mem(riscv_types_pkg::MEM_LD, 64'h3008, 32'd0, riscv_types_pkg::MEM_SD, 64'h3000);
        drive_mem(riscv_types_pkg::MEM_LWU, 64'h3000, 32'd4, riscv_types_pkg::MEM_SD, 64'h3000);

        mem_cycles = 0;   // count only what the random phase reaches
        sl_cycles  = 0;
        for (n = 0; n < RANDOM_CYCLES; n++) begin
            random_cycle();
        end
        idle_cycle();
        @(negedge clk);

        if (mem_cycles == 0 || sl_cycles == 0) begin
            $display("random cycles never expected a memory-stage or store-to-load stall");
            $display("Test failed");
            $fatal(1, "random stimulus did not reach all stall kinds");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 4;   // period of 8

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // low across the first two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: logic/hazard_unit.sv
module hazard_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    // decode instruction
    input  riscv_types_pkg::xlen_t     id_pc,
    input  riscv_types_pkg::reg_addr_t rs1_addr,
    input  riscv_types_pkg::reg_addr_t rs2_addr,
    input  riscv_types_pkg::mem_op_t   id_mem_op,
    input  riscv_types_pkg::xlen_t     id_base,
    input  riscv_types_pkg::imm_t      id_imm,
    // execute instruction
    input  riscv_types_pkg::reg_addr_t ex_rd_addr,
    input  riscv_types_pkg::mem_op_t   ex_mem_op,
    input  riscv_types_pkg::xlen_t     ex_store_addr,
    // memory / writeback instruction
    input  riscv_types_pkg::reg_addr_t wb_rd_addr,
    input  logic                       mem_is_store,
    // stall levels
    output logic                       stall_id,
    output logic                       stall_mem,
    output logic                       stall_wb,
    output logic                       stall_store_load
);

    logic ex_hit;
    logic wb_hit;
    logic dual_hit;
    logic overlap_hit;

    // register dependencies against ex and wb destinations
    reg_dep_check i_reg_dep_check (
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .ex_rd_addr   (ex_rd_addr),
        .wb_rd_addr   (wb_rd_addr),
        .ex_mem_op    (ex_mem_op),
        .mem_is_store (mem_is_store),
        .ex_hit       (ex_hit),
        .wb_hit       (wb_hit),
        .dual_hit     (dual_hit)
    );

    // load in decode vs store in execute
    store_load_check i_store_load_check (
        .id_mem_op     (id_mem_op),
        .ex_mem_op     (ex_mem_op),
        .id_base       (id_base),
        .ex_store_addr (ex_store_addr),
        .id_imm        (id_imm),
        .overlap_hit   (overlap_hit)
    );

    stall_arbiter i_stall_arbiter (
        .clk              (clk),
        .rst_n            (rst_n),
        .id_pc            (id_pc),
        .ex_mem_op        (ex_mem_op),
        .ex_hit           (ex_hit),
        .wb_hit           (wb_hit),
        .dual_hit         (dual_hit),
        .overlap_hit      (overlap_hit),
        .stall_id         (stall_id),
        .stall_mem        (stall_mem),
        .stall_wb         (stall_wb),
        .stall_store_load (stall_store_load)
    );

endmodule

// File: logic/stall_arbiter.sv
`include "hazard_macros.svh"

module stall_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  riscv_types_pkg::xlen_t   id_pc,
    input  riscv_types_pkg::mem_op_t ex_mem_op,
    input  logic                     ex_hit,
    input  logic                     wb_hit,
    input  logic                     dual_hit,
    input  logic                     overlap_hit,
    output logic                     stall_id,
    output logic                     stall_mem,
    output logic                     stall_wb,
    output logic                     stall_store_load
);

    hazard_pkg::arb_state_t state_q;
    hazard_pkg::arb_state_t state_d;
    logic                   pc_real;
    logic                   gate_open;
    logic                   long_path;

    // signed sub-doubleword loads need an extra stage for sign extension
    assign long_path = ex_mem_op inside {riscv_types_pkg::MEM_LB, riscv_types_pkg::MEM_LH,
                                         riscv_types_pkg::MEM_LW};

    assign pc_real   = (id_pc != `HZ_PC_NULL) && (id_pc != `HZ_PC_BOOT);
    assign gate_open = pc_real && (state_q == hazard_pkg::ARB_RUN);

    always_comb begin
        stall_id         = 1'b0;
        stall_mem        = 1'b0;
        stall_wb         = 1'b0;
        stall_store_load = 1'b0;
        if (gate_open) begin
            if (long_path) begin
                if (dual_hit) begin
                    stall_id  = 1'b1;
                    stall_mem = 1'b1;
                    stall_wb  = 1'b1;
                end else if (ex_hit) begin
                    stall_id  = 1'b1;
                    stall_mem = 1'b1;   // result only exists after mem
                end else if (wb_hit) begin
                    stall_id = 1'b1;
                    stall_wb = 1'b1;
                end
            end else begin
                if (dual_hit) begin
                    stall_id = 1'b1;
                    stall_wb = 1'b1;
                end else if (ex_hit) begin
                    stall_id = 1'b1;
                end else if (wb_hit) begin
                    stall_id = 1'b1;
                    stall_wb = 1'b1;
                end else if (overlap_hit) begin
                    // store data not in memory yet
                    stall_id         = 1'b1;
                    stall_store_load = 1'b1;
                end
            end
        end
    end

    // one masked cycle after a mem stall so the same dependency is not stalled twice
    always_comb begin
        case (state_q)
            hazard_pkg::ARB_RUN:      state_d = stall_mem ? hazard_pkg::ARB_MEM_HOLD
                                                          : hazard_pkg::ARB_RUN;
            hazard_pkg::ARB_MEM_HOLD: state_d = hazard_pkg::ARB_RUN;
            default:                  state_d = hazard_pkg::ARB_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= hazard_pkg::ARB_RUN;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: logic/store_load_check.sv
`include "hazard_macros.svh"

module store_load_check (
    input  riscv_types_pkg::mem_op_t id_mem_op,
    input  riscv_types_pkg::mem_op_t ex_mem_op,
    input  riscv_types_pkg::xlen_t   id_base,
    input  riscv_types_pkg::xlen_t   ex_store_addr,
    input  riscv_types_pkg::imm_t    id_imm,
    output logic                     overlap_hit
);

    riscv_types_pkg::xlen_t  load_addr;
    riscv_types_pkg::xlen_t  imm_ext;
    hazard_pkg::byte_mask_t  load_mask;
    hazard_pkg::byte_mask_t  store_mask;
    logic                    id_is_load;
    logic                    ex_is_store;
    logic                    same_dword;

    // lanes touched by an aligned access of the given op
    function automatic hazard_pkg::byte_mask_t lane_mask(
        input riscv_types_pkg::mem_op_t op,
        input logic [2:0]               offset
    );
        hazard_pkg::byte_mask_t size_mask;
        case (op)
            riscv_types_pkg::MEM_LB,
            riscv_types_pkg::MEM_LBU,
            riscv_types_pkg::MEM_SB:  size_mask = 8'h01;
            riscv_types_pkg::MEM_LH,
            riscv_types_pkg::MEM_LHU,
            riscv_types_pkg::MEM_SH:  size_mask = 8'h03;
            riscv_types_pkg::MEM_LW,
            riscv_types_pkg::MEM_LWU,
            riscv_types_pkg::MEM_SW:  size_mask = 8'h0f;
            riscv_types_pkg::MEM_LD,
            riscv_types_pkg::MEM_SD:  size_mask = 8'hff;
            default:                  size_mask = 8'h00;
        endcase
        return size_mask << offset;
    endfunction

    assign id_is_load = id_mem_op inside {riscv_types_pkg::MEM_LB, riscv_types_pkg::MEM_LH,
                                          riscv_types_pkg::MEM_LW, riscv_types_pkg::MEM_LD,
                                          riscv_types_pkg::MEM_LBU, riscv_types_pkg::MEM_LHU,
                                          riscv_types_pkg::MEM_LWU};
    assign ex_is_store = ex_mem_op inside {riscv_types_pkg::MEM_SB, riscv_types_pkg::MEM_SH,
                                           riscv_types_pkg::MEM_SW, riscv_types_pkg::MEM_SD};

    // effective load address, offset widened to xlen
    assign imm_ext   = {{(`HZ_XLEN-`HZ_IMM_WIDTH){id_imm[`HZ_IMM_WIDTH-1]}}, id_imm};
    assign load_addr = id_base + imm_ext;

    assign load_mask  = lane_mask(id_mem_op, load_addr[2:0]);
    assign store_mask = lane_mask(ex_mem_op, ex_store_addr[2:0]);

    assign same_dword = (load_addr[`HZ_XLEN-1:3] == ex_store_addr[`HZ_XLEN-1:3]);

    // load would read a byte the store has not written yet
    assign overlap_hit = id_is_load && ex_is_store && same_dword
                         && ((load_mask & store_mask) != '0);

endmodule

// File: logic/reg_dep_check.sv
module reg_dep_check (
    input  riscv_types_pkg::reg_addr_t rs1_addr,
    input  riscv_types_pkg::reg_addr_t rs2_addr,
    input  riscv_types_pkg::reg_addr_t ex_rd_addr,
    input  riscv_types_pkg::reg_addr_t wb_rd_addr,
    input  riscv_types_pkg::mem_op_t   ex_mem_op,
    input  logic                       mem_is_store,
    output logic                       ex_hit,
    output logic                       wb_hit,
    output logic                       dual_hit
);

    logic ex_is_store;
    logic ex_rd_valid;
    logic wb_rd_valid;
    logic rs1_ex;
    logic rs2_ex;
    logic rs1_wb;
    logic rs2_wb;

    // stores write no register
    assign ex_is_store = ex_mem_op inside {riscv_types_pkg::MEM_SB, riscv_types_pkg::MEM_SH,
                                           riscv_types_pkg::MEM_SW, riscv_types_pkg::MEM_SD};

    assign ex_rd_valid = (ex_rd_addr != '0);   // x0 is never a dependency
    assign wb_rd_valid = (wb_rd_addr != '0);

    assign rs1_ex = (rs1_addr == ex_rd_addr);
    assign rs2_ex = (rs2_addr == ex_rd_addr);
    assign rs1_wb = (rs1_addr == wb_rd_addr);
    assign rs2_wb = (rs2_addr == wb_rd_addr);

    assign ex_hit = (rs1_ex || rs2_ex) && ex_rd_valid && !ex_is_store;
    assign wb_hit = (rs1_wb || rs2_wb) && wb_rd_valid && !mem_is_store;

    // each source waits on a different stage
    assign dual_hit = ((rs1_ex && rs2_wb) || (rs1_wb && rs2_ex))
                      && ex_rd_valid && wb_rd_valid;

endmodule

// File: logic/hazard_pkg.sv
`include "hazard_macros.svh"

package hazard_pkg;

    // one bit per byte lane of a doubleword
    typedef logic [`HZ_XLEN/8-1:0] byte_mask_t;

    // arbiter state
    typedef enum logic {
        ARB_RUN,        // normal stall evaluation
        ARB_MEM_HOLD    // cycle after a memory-stage stall, all stalls masked
    } arb_state_t;

endpackage

// File: logic/riscv_types_pkg.sv
`include "hazard_macros.svh"

package riscv_types_pkg;

    typedef logic [`HZ_XLEN-1:0] xlen_t;           // pc, base, address
    typedef logic [`HZ_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`HZ_IMM_WIDTH-1:0] imm_t;       // already sign-extended

    // memory operation carried down the pipe
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,   // signed loads below 64 bits take the long path
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LD   = 4'd4,
        MEM_LBU  = 4'd5,
        MEM_LHU  = 4'd6,
        MEM_LWU  = 4'd7,
        MEM_SB   = 4'd8,
        MEM_SH   = 4'd9,
        MEM_SW   = 4'd10,
        MEM_SD   = 4'd11
    } mem_op_t;

endpackage

// File: include/hazard_macros.svh
`ifndef HAZARD_MACROS_SVH
`define HAZARD_MACROS_SVH

// datapath and address width
`define HZ_XLEN 64

// architectural register index
`define HZ_REG_ADDR_WIDTH 5

// sign-extended offset from the decoder
`define HZ_IMM_WIDTH 32

// pcs where decode holds no real instruction
`define HZ_PC_NULL 64'h0000_0000_0000_0000
`define HZ_PC_BOOT 64'h0000_0000_8000_0000

`endif
